/* common/wdata_align_pkg.sv */
/* wdata align package
   limits, vector types and packed records shared by the AW/W alignment and hold block */
`default_nettype none

package wdata_align_pkg;

  // longest AXI burst the block accepts, in beats
  localparam int MaxBurstLen = 16;
  // skew that can be tracked, counted in maximum-length bursts
  localparam int MaxTransactionSkew = 2;
  // ceiling of either excess counter
  localparam int MaxExcessCount = MaxTransactionSkew * MaxBurstLen;
  // one length entry per burst of tracked skew
  localparam int LenFifoDepth = MaxTransactionSkew;
  // pointer and occupancy widths of the length FIFO
  localparam int LenPtrWidth = (LenFifoDepth > 1) ? $clog2(LenFifoDepth) : 1;
  localparam int LenCntWidth = $clog2(LenFifoDepth + 1);

  // AXI awlen, zero based
  typedef logic [$clog2(MaxBurstLen)-1:0] awlen_t;
  // beats moved in one cycle, 0 up to a full burst
  typedef logic [$clog2(MaxBurstLen + 1)-1:0] beat_len_t;
  // value of one excess counter, 0 up to MaxExcessCount
  typedef logic [$clog2(MaxExcessCount + 1)-1:0] excess_cnt_t;
  typedef logic [LenPtrWidth-1:0] len_ptr_t;
  typedef logic [LenCntWidth-1:0] len_cnt_t;

  // handshakes completed on the downstream side this cycle
  typedef struct packed {
    logic aw_beat;
    logic w_beat;
    awlen_t aw_len;
  } chan_beats_t;

  // net AW versus W growth this cycle; at most one direction bit is set
  typedef struct packed {
    logic aw_ahead;
    logic w_ahead;
    beat_len_t mag;
  } beat_delta_t;

  // flags the gate needs from the two excess counters
  typedef struct packed {
    logic aw_excess;
    logic w_excess;
    logic aw_full;
    logic w_full;
    logic aligned;
  } skew_status_t;

endpackage

`default_nettype wire

/* hw/skew_tracker/beat_delta_decode.sv */
/* beat delta decode
   turns the AW and W beats forwarded this cycle into a direction and a magnitude */
`timescale 1ns/1ps
`default_nettype none

module beat_delta_decode (
  input  wdata_align_pkg::chan_beats_t beats,
  output wdata_align_pkg::beat_delta_t delta
);

  import wdata_align_pkg::*;

  // beats promised by an AW forwarded this cycle
  beat_len_t aw_burst_len;
  // contribution of each channel in this cycle
  beat_len_t aw_incr;
  beat_len_t w_incr;

  // awlen is zero based, so a burst carries one beat more than the field says.
  // the sum is done at beat_len_t width so a 16-beat burst does not wrap to 0
  assign aw_burst_len = beat_len_t'(beats.aw_len) + beat_len_t'(1);

  // an AW handshake adds its whole burst at once
  assign aw_incr = beats.aw_beat ? aw_burst_len : '0;

  // a W handshake is always a single beat
  assign w_incr = beats.w_beat ? beat_len_t'(1) : '0;

  always_comb begin
    delta.aw_ahead = 1'b0;
    delta.w_ahead = 1'b0;
    delta.mag = '0;
    if (aw_incr > w_incr) begin
      // AW promised more than W delivered this cycle
      delta.aw_ahead = 1'b1;
      delta.mag = aw_incr - w_incr;
    end else if (w_incr > aw_incr) begin
      // a lone W beat with no AW in the same cycle
      delta.w_ahead = 1'b1;
      delta.mag = w_incr - aw_incr;
    end
    // equal growth leaves both flags low and the magnitude at zero
  end

endmodule

`default_nettype wire

/* hw/skew_tracker/skew_counters.sv */
/* skew counters
   excess-AW and excess-W beat counters and the status flags taken from them */
`timescale 1ns/1ps
`default_nettype none

module skew_counters (
  input  logic clk,
  input  logic rst,
  input  wdata_align_pkg::beat_delta_t delta,
  output wdata_align_pkg::skew_status_t status
);

  import wdata_align_pkg::*;

  // W beats still owed to AW bursts that went downstream
  excess_cnt_t excess_aw;
  // W beats sent with no AW to cover them yet
  excess_cnt_t excess_w;
  // the delta magnitude at counter width
  excess_cnt_t mag;
  // portion of the delta that cancels the opposite counter
  excess_cnt_t w_cancel;
  excess_cnt_t aw_cancel;
  excess_cnt_t excess_aw_next;
  excess_cnt_t excess_w_next;

  assign mag = excess_cnt_t'(delta.mag);

  // an AW-ahead delta eats into the W excess first, never below zero
  assign w_cancel = (mag < excess_w) ? mag : excess_w;

  // a W-ahead delta eats into the AW excess first
  assign aw_cancel = (mag < excess_aw) ? mag : excess_aw;

  // whatever is left after cancelling lands on the growing side,
  // which keeps at most one of the two counters non-zero
  always_comb begin
    excess_aw_next = excess_aw;
    excess_w_next = excess_w;
    if (delta.aw_ahead) begin
      excess_w_next = excess_w - w_cancel;
      excess_aw_next = excess_aw + (mag - w_cancel);
    end else if (delta.w_ahead) begin
      excess_aw_next = excess_aw - aw_cancel;
      excess_w_next = excess_w + (mag - aw_cancel);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      excess_aw <= '0;
      excess_w <= '0;
    end else begin
      excess_aw <= excess_aw_next;
      excess_w <= excess_w_next;
    end
  end

  // which side is ahead, taken from the registered values
  assign status.aw_excess = (excess_aw > excess_w);
  assign status.w_excess = (excess_w > excess_aw);

  // no room left for another maximum-length AW burst
  assign status.aw_full = (excess_aw >= excess_cnt_t'(MaxExcessCount - MaxBurstLen));

  // no room left for one more lone W beat
  assign status.w_full = (excess_w >= excess_cnt_t'(MaxExcessCount - 1));

  // every forwarded AW burst has all its data
  assign status.aligned = (excess_aw == '0) && (excess_w == '0);

endmodule

`default_nettype wire

/* hw/channel_gate.sv */
/* channel gate
   holds off AW and W on skew, feeds fake W during alignment and signals done */
`timescale 1ns/1ps
`default_nettype none

module channel_gate (
  // upstream side
  input  logic upstream_awvalid,
  output logic upstream_awready,
  input  wdata_align_pkg::awlen_t upstream_awlen,
  input  logic upstream_wvalid,
  output logic upstream_wready,
  // downstream side
  output logic downstream_awvalid,
  input  logic downstream_awready,
  output logic downstream_wvalid,
  input  logic downstream_wready,
  // isolator handshake
  input  logic align_and_hold_req,
  output logic align_and_hold_done,
  // state from the tracker and the length FIFO
  input  wdata_align_pkg::skew_status_t status,
  input  logic len_fifo_ready,
  output wdata_align_pkg::chan_beats_t beats
);

  import wdata_align_pkg::*;

  logic holdoff_aw;
  logic holdoff_w;
  // AW handshake completing downstream in this cycle
  logic aw_beat;
  // upstream is cut off and W is driven from inside the block
  logic fake_w;

  // an alignment request blocks upstream and fakes W for as long as it is high
  assign fake_w = align_and_hold_req;

  // done only needs the request and the registered counters,
  // so it cannot loop back through the holdoffs below
  assign align_and_hold_done = align_and_hold_req && status.aligned;

  assign aw_beat = downstream_awvalid && downstream_awready;

  // AW waits when another full burst would overflow the excess count,
  // when the length FIFO has no free entry,
  // or while an alignment is draining, since new bursts would only add work
  assign holdoff_aw = status.aw_full || !len_fifo_ready || align_and_hold_req;

  // W waits on a full W counter, on a W lead during alignment, once aligned and held,
  // and whenever no forwarded AW burst still needs data.
  // the last case is what keeps W from ever leading AW
  assign holdoff_w = status.w_full
                     || (align_and_hold_req && status.w_excess)
                     || align_and_hold_done
                     || !(status.aw_excess || aw_beat);

  // upstream ready follows downstream ready, so back-pressure passes straight through
  assign upstream_awready = downstream_awready && !holdoff_aw && !fake_w;
  assign upstream_wready = downstream_wready && !holdoff_w && !fake_w;

  // zero-cycle forwarding; during alignment the W valid comes from the request
  assign downstream_awvalid = upstream_awvalid && !holdoff_aw;
  assign downstream_wvalid = (upstream_wvalid || fake_w) && !holdoff_w;

  // report what actually went downstream to the tracker and the wlast logic.
  // the length is only meaningful together with aw_beat
  assign beats.aw_beat = aw_beat;
  assign beats.w_beat = downstream_wvalid && downstream_wready;
  assign beats.aw_len = upstream_awlen;

endmodule

`default_nettype wire

/* hw/wlast_tracker.sv */
/* wlast tracker
   queues forwarded AW lengths and counts W beats to rebuild downstream wlast */
`timescale 1ns/1ps
`default_nettype none

module wlast_tracker (
  input  logic clk,
  input  logic rst,
  input  wdata_align_pkg::chan_beats_t beats,
  input  logic downstream_wready,
  output logic len_fifo_ready,
  output logic wlast
);

  import wdata_align_pkg::*;

  // length storage, payload only
  awlen_t len_mem [LenFifoDepth];
  len_ptr_t wr_ptr;
  len_ptr_t rd_ptr;
  len_cnt_t len_count;
  logic len_empty;
  // length of the burst that W is currently filling
  awlen_t head_len;
  // W beats already sent in the current burst
  awlen_t beat_cnt;
  // last beat of a burst is taken downstream
  logic pop_last;
  logic do_write;
  logic do_read;

  assign len_empty = (len_count == '0);

  // free entry available; the gate holds AW off otherwise
  assign len_fifo_ready = (len_count != len_cnt_t'(LenFifoDepth));

  // with nothing queued, the AW forwarded this same cycle is already the head.
  // W never leads AW, so an empty FIFO with a W beat always has that AW present
  assign head_len = len_empty ? beats.aw_len : len_mem[rd_ptr];

  // the beat whose index matches the zero-based length closes the burst
  assign wlast = (beat_cnt == head_len);

  // the burst retires when its final beat completes the downstream handshake
  assign pop_last = beats.w_beat && downstream_wready && wlast;

  // a single-beat burst that arrives and finishes in the same empty cycle
  // passes straight through and is never written
  assign do_write = beats.aw_beat && len_fifo_ready && !(len_empty && pop_last);
  assign do_read = pop_last && !len_empty;

  always_ff @(posedge clk) begin
    if (do_write) begin
      len_mem[wr_ptr] <= beats.aw_len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      len_count <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == len_ptr_t'(LenFifoDepth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == len_ptr_t'(LenFifoDepth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy moves only when exactly one side is active
      if (do_write && !do_read) begin
        len_count <= len_count + 1'b1;
      end else if (do_read && !do_write) begin
        len_count <= len_count - 1'b1;
      end
    end
  end

  // beat position inside the burst at the FIFO head
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (pop_last) begin
      beat_cnt <= '0;
    end else if (beats.w_beat) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/wdata_align_top.sv */
/* AW/W alignment and hold, top level
   ties skew tracking, channel gating and wlast regeneration together */
`timescale 1ns/1ps
`default_nettype none

module wdata_align_top (
  input  logic clk,
  input  logic rst,
  // upstream AW
  input  logic upstream_awvalid,
  output logic upstream_awready,
  input  wdata_align_pkg::awlen_t upstream_awlen,
  // upstream W, its wlast is rebuilt locally so it is not taken
  input  logic upstream_wvalid,
  output logic upstream_wready,
  // downstream AW
  output logic downstream_awvalid,
  input  logic downstream_awready,
  // downstream W
  output logic downstream_wvalid,
  input  logic downstream_wready,
  output logic downstream_wlast,
  // isolator handshake
  input  logic align_and_hold_req,
  output logic align_and_hold_done
);

  import wdata_align_pkg::*;

  // beats forwarded downstream in the current cycle
  chan_beats_t beats;
  // signed change of AW versus W beats for the counters
  beat_delta_t delta;
  // registered skew flags, they change one cycle after a forwarded beat
  skew_status_t status;
  // the length FIFO can take one more forwarded AW
  logic len_fifo_ready;

  // forwarded beats into a sign and magnitude
  beat_delta_decode beat_delta_decode_inst (
    .beats (beats),
    .delta (delta)
  );

  // excess-AW and excess-W counters
  skew_counters skew_counters_inst (
    .clk    (clk),
    .rst    (rst),
    .delta  (delta),
    .status (status)
  );

  // holdoffs, fake W insertion and the done flag
  channel_gate channel_gate_inst (
    .upstream_awvalid    (upstream_awvalid),
    .upstream_awready    (upstream_awready),
    .upstream_awlen      (upstream_awlen),
    .upstream_wvalid     (upstream_wvalid),
    .upstream_wready     (upstream_wready),
    .downstream_awvalid  (downstream_awvalid),
    .downstream_awready  (downstream_awready),
    .downstream_wvalid   (downstream_wvalid),
    .downstream_wready   (downstream_wready),
    .align_and_hold_req  (align_and_hold_req),
    .align_and_hold_done (align_and_hold_done),
    .status              (status),
    .len_fifo_ready      (len_fifo_ready),
    .beats               (beats)
  );

  // wlast comes from the queued AW lengths, so fake beats close bursts correctly
  wlast_tracker wlast_tracker_inst (
    .clk               (clk),
    .rst               (rst),
    .beats             (beats),
    .downstream_wready (downstream_wready),
    .len_fifo_ready    (len_fifo_ready),
    .wlast             (downstream_wlast)
  );

endmodule

`default_nettype wire

/* tests/wdata_align_model.svh */
/* wdata align reference model
   tracks beat skew and queued burst lengths, predicts gating and wlast */
`ifndef WDATA_ALIGN_MODEL_SVH
`define WDATA_ALIGN_MODEL_SVH

// AW beats promised but not yet delivered, and W beats with no AW behind them
int m_excess_aw;
int m_excess_w;
// running totals of forwarded beats on each channel
int m_cum_aw;
int m_cum_w;
// beat position inside the burst at the head of the queue
int m_beat_cnt;
// zero-based lengths of forwarded bursts, oldest first
int m_len_q[$];

// predictions for the current cycle
logic p_up_awready;
logic p_up_wready;
logic p_ds_awvalid;
logic p_ds_wvalid;
logic p_done;
logic p_wlast;

task automatic model_reset();
  m_excess_aw = 0;
  m_excess_w = 0;
  m_cum_aw = 0;
  m_cum_w = 0;
  m_beat_cnt = 0;
  m_len_q.delete();
endtask

// predicts the combinational outputs from this cycle's inputs and the model state
task automatic model_predict(input logic awvalid, input awlen_t awlen, input logic wvalid,
                             input logic awready, input logic wready, input logic req);
  logic hold_aw;
  logic hold_w;
  logic aw_go;
  int head;
  // no room for a full burst, every length slot taken, or an alignment running
  hold_aw = (m_excess_aw >= MaxExcessCount - MaxBurstLen)
            || (m_len_q.size() >= LenFifoDepth) || req;
  p_done = req && (m_excess_aw == 0) && (m_excess_w == 0);
  aw_go = awvalid && awready && !hold_aw;
  // W needs an AW to cover it, either outstanding or arriving now
  hold_w = p_done || !((m_excess_aw > 0) || aw_go);
  p_ds_awvalid = awvalid && !hold_aw;
  p_up_awready = awready && !hold_aw;
  p_ds_wvalid = (wvalid || req) && !hold_w;
  p_up_wready = wready && !hold_w && !req;
  // with nothing queued the burst starting this cycle is the one being filled
  if (m_len_q.size() > 0) begin
    head = m_len_q[0];
  end else begin
    head = aw_go ? int'(awlen) : -1;
  end
  p_wlast = (m_beat_cnt == head);
endtask

// applies the handshakes seen in the cycle that just ended
task automatic model_update(input logic aw_hs, input int aw_len, input logic w_hs);
  int net;
  if (aw_hs) begin
    m_len_q.push_back(aw_len);
    m_cum_aw += aw_len + 1;
  end
  if (w_hs) begin
    m_cum_w += 1;
    if (m_len_q.size() > 0 && m_beat_cnt == m_len_q[0]) begin
      void'(m_len_q.pop_front());
      m_beat_cnt = 0;
    end else begin
      m_beat_cnt += 1;
    end
  end
  // net skew splits into the side that is ahead
  net = m_excess_aw - m_excess_w + (aw_hs ? aw_len + 1 : 0) - (w_hs ? 1 : 0);
  m_excess_aw = (net > 0) ? net : 0;
  m_excess_w = (net < 0) ? -net : 0;
endtask

`endif

/* tests/tb_wdata_align.sv */
/* testbench for the AW/W alignment and hold block
   random traffic and alignment episodes checked against a reference model */
`timescale 1ns/1ps
`default_nettype none

module tb_wdata_align;

  import wdata_align_pkg::*;

  localparam int NumEpisodes = 12;
  localparam int DoneTimeout = 200;

  logic clk;
  logic rst;
  logic upstream_awvalid;
  logic upstream_awready;
  awlen_t upstream_awlen;
  logic upstream_wvalid;
  logic upstream_wready;
  logic downstream_awvalid;
  logic downstream_awready;
  logic downstream_wvalid;
  logic downstream_wready;
  logic downstream_wlast;
  logic align_and_hold_req;
  logic align_and_hold_done;

  int seed = 86835;
  int errors = 0;
  int checks = 0;
  int ep;
  logic timed_out = 1'b0;
  // done as seen at the last falling edge, used by the request driver
  logic done_seen = 1'b0;
  // handshakes latched at the falling edge, applied to the model on the rising edge
  logic aw_hs_l = 1'b0;
  logic w_hs_l = 1'b0;
  int aw_len_l = 0;

  `include "wdata_align_model.svh"

  wdata_align_top wdata_align_top_inst (
    .clk                 (clk),
    .rst                 (rst),
    .upstream_awvalid    (upstream_awvalid),
    .upstream_awready    (upstream_awready),
    .upstream_awlen      (upstream_awlen),
    .upstream_wvalid     (upstream_wvalid),
    .upstream_wready     (upstream_wready),
    .downstream_awvalid  (downstream_awvalid),
    .downstream_awready  (downstream_awready),
    .downstream_wvalid   (downstream_wvalid),
    .downstream_wready   (downstream_wready),
    .downstream_wlast    (downstream_wlast),
    .align_and_hold_req  (align_and_hold_req),
    .align_and_hold_done (align_and_hold_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_count(input string name, input excess_cnt_t actual,
                             input excess_cnt_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  // new random upstream valids, length and downstream readies, readies biased high
  task automatic drive_traffic();
    logic [31:0] r;
    r = $random(seed);
    upstream_awvalid <= r[0];
    upstream_wvalid <= r[1];
    downstream_awready <= r[2] | r[3];
    downstream_wready <= r[4] | r[5];
    upstream_awlen <= awlen_t'(r[11:8]);
  endtask

  // one request episode; req only falls after done has been seen
  task automatic align_and_hold();
    int waited;
    logic [31:0] r;
    @(posedge clk);
    align_and_hold_req <= 1'b1;
    drive_traffic();
    waited = 0;
    while (!done_seen && waited < DoneTimeout) begin
      @(posedge clk);
      drive_traffic();
      waited++;
    end
    if (!done_seen) begin
      report_error("align_and_hold_done did not rise in time");
      timed_out = 1'b1;
    end else begin
      // hold aligned for a few cycles while upstream keeps pushing
      r = $random(seed);
      repeat (1 + r[2:0]) begin
        @(posedge clk);
        drive_traffic();
      end
      @(posedge clk);
      align_and_hold_req <= 1'b0;
      drive_traffic();
    end
  endtask

  // outputs are stable at the falling edge, so prediction and checks happen there
  always @(negedge clk) begin
    if (!rst) begin
      model_predict(upstream_awvalid, upstream_awlen, upstream_wvalid,
                    downstream_awready, downstream_wready, align_and_hold_req);
      check_bit("upstream_awready", upstream_awready, p_up_awready);
      check_bit("upstream_wready", upstream_wready, p_up_wready);
      check_bit("downstream_awvalid", downstream_awvalid, p_ds_awvalid);
      check_bit("downstream_wvalid", downstream_wvalid, p_ds_wvalid);
      check_bit("align_and_hold_done", align_and_hold_done, p_done);
      // wlast only has a meaning on a valid W beat
      if (downstream_wvalid && p_ds_wvalid) begin
        check_bit("downstream_wlast", downstream_wlast, p_wlast);
      end
      if (m_cum_w > m_cum_aw) begin
        report_error("forwarded W beats ran ahead of forwarded AW beats");
      end
      check_count("excess_aw", wdata_align_top_inst.skew_counters_inst.excess_aw,
                  excess_cnt_t'(m_cum_aw - m_cum_w));
      check_count("excess_w", wdata_align_top_inst.skew_counters_inst.excess_w,
                  excess_cnt_t'(m_excess_w));
      if (downstream_awvalid && ((m_excess_aw >= MaxExcessCount - MaxBurstLen)
                                 || (m_len_q.size() >= LenFifoDepth))) begin
        report_error("AW forwarded beyond the skew limit");
      end
      if (align_and_hold_req && (upstream_awready || upstream_wready || downstream_awvalid)) begin
        report_error("traffic accepted while align and hold was requested");
      end
      if (align_and_hold_done && downstream_wvalid) begin
        report_error("W still valid after alignment was done");
      end
      done_seen = align_and_hold_done;
      aw_hs_l = downstream_awvalid && downstream_awready;
      w_hs_l = downstream_wvalid && downstream_wready;
      aw_len_l = int'(upstream_awlen);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      model_reset();
    end else begin
      model_update(aw_hs_l, aw_len_l, w_hs_l);
    end
    aw_hs_l = 1'b0;
    w_hs_l = 1'b0;
  end

  initial begin
    rst = 1'b1;
    upstream_awvalid = 1'b0;
    upstream_awlen = '0;
    upstream_wvalid = 1'b0;
    downstream_awready = 1'b0;
    downstream_wready = 1'b0;
    align_and_hold_req = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // free traffic, then an alignment episode, repeated
    for (ep = 0; ep < NumEpisodes && !timed_out; ep++) begin
      repeat (20 + ($random(seed) & 63)) begin
        @(posedge clk);
        drive_traffic();
      end
      if (!timed_out) begin
        align_and_hold();
      end
    end
    @(posedge clk);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $display("errors %0d, checks %0d, episodes %0d", errors, checks, ep);
    $finish;
  end

endmodule

`default_nettype wire

/* wdata_align.f */
+incdir+tests
common/wdata_align_pkg.sv
hw/skew_tracker/beat_delta_decode.sv
hw/skew_tracker/skew_counters.sv
hw/channel_gate.sv
hw/wlast_tracker.sv
hw/wdata_align_top.sv
tests/tb_wdata_align.sv
